// File: source/dma_pkg.sv
package dma_pkg;

    localparam int bus_width       = 32;
    localparam int n_streams_max   = 4;    // one status byte per stream
    localparam int word_addr_width = 5;    // word index from i_addr[6:2]
    localparam int ndtr_width      = 16;

    // word map
    localparam logic [word_addr_width-1:0] addr_lisr  = 5'd0;
    localparam logic [word_addr_width-1:0] addr_lifcr = 5'd1;
    localparam int stream_base     = 2;
    localparam int regs_per_stream = 4;

    // offsets inside one stream
    localparam logic [1:0] off_cr   = 2'd0;
    localparam logic [1:0] off_ndtr = 2'd1;
    localparam logic [1:0] off_par  = 2'd2;
    localparam logic [1:0] off_mar  = 2'd3;

    // bit positions inside a stream byte of LISR and LIFCR
    localparam int flag_tc = 5;
    localparam int flag_ht = 4;
    localparam int flag_te = 3;

    // defined CR bits, the rest reads as zero
    localparam logic [bus_width-1:0] cr_used_mask = 32'h0e03_7edd;

    typedef enum logic [1:0] {
        periph_to_mem,
        mem_to_periph,
        mem_to_mem
    } dir_t;

    typedef struct packed {
        logic [3:0] rsv_31_28;
        logic [2:0] chsel;
        logic [6:0] rsv_24_18;
        logic [1:0] pl;
        logic       rsv_15;
        logic [1:0] msize;
        logic [1:0] psize;
        logic       minc;
        logic       pinc;
        logic       rsv_8;
        dir_t       dir;
        logic       rsv_5;
        logic       tcie;
        logic       htie;
        logic       teie;
        logic       rsv_1;
        logic       en;
    } cr_fields_t;

    typedef union packed {
        cr_fields_t      f;
        logic [3:0][7:0] b;    // byte lanes for strobed writes
    } cr_word_t;

endpackage

// File: source/dma_reg_decode.sv
module dma_reg_decode #(
    parameter int n_streams = 2
) (
    input  logic [dma_pkg::bus_width-1:0] i_addr,
    input  logic                          i_write_en,
    input  logic                          i_read_en,
    output logic                          o_cr_we   [n_streams-1:0],
    output logic                          o_ndtr_we [n_streams-1:0],
    output logic                          o_par_we  [n_streams-1:0],
    output logic                          o_mar_we  [n_streams-1:0],
    output logic                          o_lifcr_we,
    output logic                          o_sel_lisr,
    output logic [n_streams-1:0]          o_sel_stream,
    output logic [1:0]                    o_sel_reg,
    output logic                          o_sel_valid
);
    import dma_pkg::*;

    logic [word_addr_width-1:0] word;
    logic [word_addr_width-1:0] rel;
    logic [word_addr_width-1:0] stream_idx;
    logic [1:0]                 reg_off;
    logic                       in_streams;

    assign word       = i_addr[word_addr_width+1:2];
    assign rel        = word - word_addr_width'(stream_base);
    assign stream_idx = word_addr_width'(rel / regs_per_stream);
    assign reg_off    = 2'(rel % regs_per_stream);

    // anything past the last stream is unmapped
    assign in_streams = (word >= stream_base) && (stream_idx < n_streams);

    assign o_lifcr_we  = i_write_en && (word == addr_lifcr);
    assign o_sel_lisr  = i_read_en && (word == addr_lisr);
    assign o_sel_reg   = reg_off;
    assign o_sel_valid = i_read_en && in_streams;

    always_comb begin
        logic hit;
        for (int s = 0; s < n_streams; s++) begin
            hit = in_streams && (stream_idx == s);
            o_cr_we[s]      = i_write_en && hit && (reg_off == off_cr);
            o_ndtr_we[s]    = i_write_en && hit && (reg_off == off_ndtr);
            o_par_we[s]     = i_write_en && hit && (reg_off == off_par);
            o_mar_we[s]     = i_write_en && hit && (reg_off == off_mar);
            o_sel_stream[s] = i_read_en && hit;
        end
    end

endmodule

// File: source/dma_stream_ctrl.sv
module dma_stream_ctrl (
    input  logic                           i_clk,
    input  logic                           i_nreset,
    input  logic [3:0]                     i_byte_strobe,
    input  logic [dma_pkg::bus_width-1:0]  i_wdata,
    input  logic                           i_cr_we,
    input  logic                           i_ndtr_we,
    input  logic                           i_par_we,
    input  logic                           i_mar_we,
    input  logic                           i_ndtr_decr,
    output dma_pkg::cr_word_t              o_cr,
    output logic [dma_pkg::ndtr_width-1:0] o_ndtr,
    output logic [dma_pkg::bus_width-1:0]  o_par,
    output logic [dma_pkg::bus_width-1:0]  o_mar,
    output logic                           o_dir_mem_to_periph,
    output logic                           o_tc_set,
    output logic                           o_ht_set
);
    import dma_pkg::*;

    // strobed byte lanes of new_word replace those of old_word
    function automatic logic [bus_width-1:0] byte_merge(
        input logic [bus_width-1:0] old_word,
        input logic [bus_width-1:0] new_word,
        input logic [3:0]           strobe
    );
        logic [bus_width-1:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    cr_word_t              cr;
    logic                  pend_en;
    logic                  busy;
    logic                  en_wr;
    logic                  start;
    logic                  stop_wr;
    logic                  done;
    logic [ndtr_width-1:0] ndtr;
    logic [ndtr_width-1:0] ndtr_shadow;
    logic [bus_width-1:0]  ndtr_merge;
    logic [bus_width-1:0]  shadow_merge;
    logic [bus_width-1:0]  par;
    logic [bus_width-1:0]  mar;

    assign busy    = cr.f.en || pend_en;    // setup is locked from here on
    assign en_wr   = i_cr_we && i_byte_strobe[0];
    assign start   = en_wr && i_wdata[0] && !busy;
    assign stop_wr = en_wr && !i_wdata[0];
    assign done    = cr.f.en && (ndtr == '0);

    always_ff @(posedge i_clk or negedge i_nreset) begin
        if (!i_nreset) begin
            cr <= '0;
        end else begin
            if (i_cr_we && !busy) begin
                for (int b = 1; b < 4; b++) begin
                    if (i_byte_strobe[b]) begin
                        cr.b[b] <= i_wdata[8*b +: 8] & cr_used_mask[8*b +: 8];
                    end
                end
            end
            if (en_wr) begin
                if (!busy) begin
                    cr.f.dir <= dir_t'(i_wdata[7:6]);
                end
                cr.f.tcie <= i_wdata[4];    // interrupt enables stay writable
                cr.f.htie <= i_wdata[3];
                cr.f.teie <= i_wdata[2];
            end
            if (done || stop_wr) begin
                cr.f.en <= 1'b0;
            end else if (pend_en) begin
                cr.f.en <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nreset) begin
        if (!i_nreset) begin
            pend_en <= 1'b0;
        end else begin
            pend_en <= start;
        end
    end

    assign ndtr_merge   = byte_merge(bus_width'(ndtr), i_wdata, i_byte_strobe);
    assign shadow_merge = byte_merge(bus_width'(ndtr_shadow), i_wdata, i_byte_strobe);

    always_ff @(posedge i_clk or negedge i_nreset) begin
        if (!i_nreset) begin
            ndtr_shadow <= '0;
        end else if (i_ndtr_we && !busy) begin
            ndtr_shadow <= shadow_merge[ndtr_width-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_nreset) begin
        if (!i_nreset) begin
            ndtr <= '0;
        end else if (i_ndtr_we && !busy) begin
            ndtr <= ndtr_merge[ndtr_width-1:0];
        end else if (start) begin
            ndtr <= ndtr_shadow;    // reload on enable
        end else if (cr.f.en && i_ndtr_decr && ndtr != '0) begin
            ndtr <= ndtr - 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_nreset) begin
        if (!i_nreset) begin
            par <= '0;
            mar <= '0;
        end else begin
            if (i_par_we && !busy) begin
                par <= byte_merge(par, i_wdata, i_byte_strobe);
            end
            if (i_mar_we && !busy) begin
                mar <= byte_merge(mar, i_wdata, i_byte_strobe);
            end
        end
    end

    assign o_cr                = cr;
    assign o_ndtr              = ndtr;
    assign o_par               = par;
    assign o_mar               = mar;
    assign o_dir_mem_to_periph = (cr.f.dir == mem_to_periph);
    assign o_tc_set            = done;
    assign o_ht_set            = cr.f.en && (ndtr == (ndtr_shadow >> 1));

endmodule

// File: source/dma_stream_flags.sv
module dma_stream_flags (
    input  logic       i_clk,
    input  logic       i_nreset,
    input  logic       i_tc_set,
    input  logic       i_ht_set,
    input  logic       i_te_set,
    input  logic [2:0] i_clr,      // {tc, ht, te}
    output logic [2:0] o_flags     // {tc, ht, te}
);

    logic [2:0] flags;
    logic [2:0] set;

    assign set = {i_tc_set, i_ht_set, i_te_set};

    // sticky, a set in the same cycle beats the clear
    always_ff @(posedge i_clk or negedge i_nreset) begin
        if (!i_nreset) begin
            flags <= 3'b000;
        end else begin
            flags <= set | (flags & ~i_clr);
        end
    end

    assign o_flags = flags;

endmodule

// File: source/dma_read_mux.sv
module dma_read_mux #(
    parameter int n_streams = 2
) (
    input  logic                           i_read_en,
    input  logic                           i_sel_lisr,
    input  logic [n_streams-1:0]           i_sel_stream,
    input  logic [1:0]                     i_sel_reg,
    input  logic                           i_sel_valid,
    input  logic [2:0]                     i_flags [n_streams-1:0],
    input  dma_pkg::cr_word_t              i_cr    [n_streams-1:0],
    input  logic [dma_pkg::ndtr_width-1:0] i_ndtr  [n_streams-1:0],
    input  logic [dma_pkg::bus_width-1:0]  i_par   [n_streams-1:0],
    input  logic [dma_pkg::bus_width-1:0]  i_mar   [n_streams-1:0],
    output logic [dma_pkg::bus_width-1:0]  o_rdata
);
    import dma_pkg::*;

    logic [bus_width-1:0] lisr;
    logic [bus_width-1:0] stream_word;

    always_comb begin
        lisr        = '0;
        stream_word = '0;
        for (int s = 0; s < n_streams; s++) begin
            lisr[8*s + flag_tc] = i_flags[s][2];
            lisr[8*s + flag_ht] = i_flags[s][1];
            lisr[8*s + flag_te] = i_flags[s][0];
            if (i_sel_stream[s]) begin
                case (i_sel_reg)
                    off_cr:   stream_word = i_cr[s];
                    off_ndtr: stream_word = {{(bus_width-ndtr_width){1'b0}}, i_ndtr[s]};
                    off_par:  stream_word = i_par[s];
                    default:  stream_word = i_mar[s];
                endcase
            end
        end
    end

    // LIFCR and holes read as zero
    always_comb begin
        if (!i_read_en) begin
            o_rdata = '0;
        end else if (i_sel_lisr) begin
            o_rdata = lisr;
        end else if (i_sel_valid) begin
            o_rdata = stream_word;
        end else begin
            o_rdata = '0;
        end
    end

endmodule

// File: source/dma_regs_top.sv
module dma_regs_top #(
    parameter int n_streams = 2
) (
    input  logic                           i_clk,
    input  logic                           i_nreset,
    input  logic [dma_pkg::bus_width-1:0]  i_addr,
    input  logic                           i_write_en,
    input  logic                           i_read_en,
    input  logic [3:0]                     i_byte_strobe,
    input  logic [dma_pkg::bus_width-1:0]  i_wdata,
    input  logic                           i_ndtr_decr [n_streams-1:0],
    input  logic                           i_te_set    [n_streams-1:0],
    output logic [dma_pkg::bus_width-1:0]  o_rdata,
    output logic [2:0]                     o_cr_chsel  [n_streams-1:0],
    output logic [1:0]                     o_cr_pl     [n_streams-1:0],
    output logic [1:0]                     o_cr_msize  [n_streams-1:0],
    output logic [1:0]                     o_cr_psize  [n_streams-1:0],
    output logic                           o_cr_minc   [n_streams-1:0],
    output logic                           o_cr_pinc   [n_streams-1:0],
    output dma_pkg::dir_t                  o_cr_dir    [n_streams-1:0],
    output logic                           o_cr_tcie   [n_streams-1:0],
    output logic                           o_cr_htie   [n_streams-1:0],
    output logic                           o_cr_teie   [n_streams-1:0],
    output logic                           o_cr_en     [n_streams-1:0],
    output logic [dma_pkg::ndtr_width-1:0] o_ndtr      [n_streams-1:0],
    output logic [dma_pkg::bus_width-1:0]  o_par       [n_streams-1:0],
    output logic [dma_pkg::bus_width-1:0]  o_mar       [n_streams-1:0],
    output logic                           o_dir_mem_to_periph [n_streams-1:0],
    output logic                           o_isr_tcif  [n_streams-1:0],
    output logic                           o_isr_htif  [n_streams-1:0],
    output logic                           o_isr_teif  [n_streams-1:0]
);
    import dma_pkg::*;

    // LISR has room for four streams only
    if (n_streams < 1 || n_streams > n_streams_max) begin : g_bad_count
        $error("n_streams must be 1 to %0d", n_streams_max);
    end

    logic                 cr_we     [n_streams-1:0];
    logic                 ndtr_we   [n_streams-1:0];
    logic                 par_we    [n_streams-1:0];
    logic                 mar_we    [n_streams-1:0];
    logic                 tc_set    [n_streams-1:0];
    logic                 ht_set    [n_streams-1:0];
    logic [2:0]           clr       [n_streams-1:0];
    logic [2:0]           flags     [n_streams-1:0];
    cr_word_t             cr        [n_streams-1:0];
    logic                 lifcr_we;
    logic                 sel_lisr;
    logic [n_streams-1:0] sel_stream;
    logic [1:0]           sel_reg;
    logic                 sel_valid;

    dma_reg_decode #(
        .n_streams (n_streams)
    ) dma_reg_decode_inst (
        .i_addr       (i_addr),
        .i_write_en   (i_write_en),
        .i_read_en    (i_read_en),
        .o_cr_we      (cr_we),
        .o_ndtr_we    (ndtr_we),
        .o_par_we     (par_we),
        .o_mar_we     (mar_we),
        .o_lifcr_we   (lifcr_we),
        .o_sel_lisr   (sel_lisr),
        .o_sel_stream (sel_stream),
        .o_sel_reg    (sel_reg),
        .o_sel_valid  (sel_valid)
    );

    for (genvar s = 0; s < n_streams; s++) begin : g_stream
        dma_stream_ctrl dma_stream_ctrl_inst (
            .i_clk               (i_clk),
            .i_nreset            (i_nreset),
            .i_byte_strobe       (i_byte_strobe),
            .i_wdata             (i_wdata),
            .i_cr_we             (cr_we[s]),
            .i_ndtr_we           (ndtr_we[s]),
            .i_par_we            (par_we[s]),
            .i_mar_we            (mar_we[s]),
            .i_ndtr_decr         (i_ndtr_decr[s]),
            .o_cr                (cr[s]),
            .o_ndtr              (o_ndtr[s]),
            .o_par               (o_par[s]),
            .o_mar               (o_mar[s]),
            .o_dir_mem_to_periph (o_dir_mem_to_periph[s]),
            .o_tc_set            (tc_set[s]),
            .o_ht_set            (ht_set[s])
        );

        // this stream's byte of LIFCR
        assign clr[s] = {3{lifcr_we & i_byte_strobe[s]}} &
                        {i_wdata[8*s + flag_tc], i_wdata[8*s + flag_ht], i_wdata[8*s + flag_te]};

        dma_stream_flags dma_stream_flags_inst (
            .i_clk    (i_clk),
            .i_nreset (i_nreset),
            .i_tc_set (tc_set[s]),
            .i_ht_set (ht_set[s]),
            .i_te_set (i_te_set[s]),
            .i_clr    (clr[s]),
            .o_flags  (flags[s])
        );

        assign o_cr_chsel[s] = cr[s].f.chsel;
        assign o_cr_pl[s]    = cr[s].f.pl;
        assign o_cr_msize[s] = cr[s].f.msize;
        assign o_cr_psize[s] = cr[s].f.psize;
        assign o_cr_minc[s]  = cr[s].f.minc;
        assign o_cr_pinc[s]  = cr[s].f.pinc;
        assign o_cr_dir[s]   = cr[s].f.dir;
        assign o_cr_tcie[s]  = cr[s].f.tcie;
        assign o_cr_htie[s]  = cr[s].f.htie;
        assign o_cr_teie[s]  = cr[s].f.teie;
        assign o_cr_en[s]    = cr[s].f.en;
        assign o_isr_tcif[s] = flags[s][2];
        assign o_isr_htif[s] = flags[s][1];
        assign o_isr_teif[s] = flags[s][0];
    end

    dma_read_mux #(
        .n_streams (n_streams)
    ) dma_read_mux_inst (
        .i_read_en    (i_read_en),
        .i_sel_lisr   (sel_lisr),
        .i_sel_stream (sel_stream),
        .i_sel_reg    (sel_reg),
        .i_sel_valid  (sel_valid),
        .i_flags      (flags),
        .i_cr         (cr),
        .i_ndtr       (o_ndtr),
        .i_par        (o_par),
        .i_mar        (o_mar),
        .o_rdata      (o_rdata)
    );

endmodule

// File: bench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int half_period  = 20,
    parameter int reset_cycles = 2
) (
    output logic o_clk,
    output logic o_nreset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #half_period o_clk = ~o_clk;
    end

    initial begin
        o_nreset = 1'b0;
        repeat (reset_cycles) @(posedge o_clk);
        #2;
        o_nreset = 1'b1;    // released just after an edge
    end

endmodule

// File: bench/tb_dma_regs.sv
module tb_dma_regs;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_streams   = 2;
    localparam int drive_delay = 2;
    localparam int wait_limit  = 10;
    localparam logic [31:0] lisr_addr  = 32'h0;
    localparam logic [31:0] lifcr_addr = 32'h4;
    // chsel 27:25, pl 17:16, sizes and incs 14:9, dir 7:6, ie 4:2, en 0
    localparam logic [31:0] cr_fields = 32'h0e03_7edd;

    logic          clk;
    logic          nreset;
    logic [31:0]   addr;
    logic          write_en;
    logic          read_en;
    logic [3:0]    strobe;
    logic [31:0]   wdata;
    logic [31:0]   rdata;
    logic          ndtr_decr [n_streams-1:0];
    logic          te_set    [n_streams-1:0];
    logic [2:0]    cr_chsel  [n_streams-1:0];
    logic [1:0]    cr_pl     [n_streams-1:0];
    logic [1:0]    cr_msize  [n_streams-1:0];
    logic [1:0]    cr_psize  [n_streams-1:0];
    logic          cr_minc   [n_streams-1:0];
    logic          cr_pinc   [n_streams-1:0];
    dma_pkg::dir_t cr_dir    [n_streams-1:0];
    logic          cr_tcie   [n_streams-1:0];
    logic          cr_htie   [n_streams-1:0];
    logic          cr_teie   [n_streams-1:0];
    logic          cr_en     [n_streams-1:0];
    logic [15:0]   ndtr      [n_streams-1:0];
    logic [31:0]   par       [n_streams-1:0];
    logic [31:0]   mar       [n_streams-1:0];
    logic          dir_m2p   [n_streams-1:0];
    logic          isr_tcif  [n_streams-1:0];
    logic          isr_htif  [n_streams-1:0];
    logic          isr_teif  [n_streams-1:0];

    logic [31:0] exp_par [n_streams-1:0];
    logic [31:0] exp_mar [n_streams-1:0];
    logic [31:0] exp_cr;
    string       test_name;
    int          test_errs;
    int          pass_count;
    int          fail_count;

    tb_clock_gen tb_clock_gen_inst (
        .o_clk    (clk),
        .o_nreset (nreset)
    );

    dma_regs_top #(
        .n_streams (n_streams)
    ) dma_regs_top_inst (
        .i_clk (clk), .i_nreset (nreset), .i_addr (addr),
        .i_write_en (write_en), .i_read_en (read_en),
        .i_byte_strobe (strobe), .i_wdata (wdata),
        .i_ndtr_decr (ndtr_decr), .i_te_set (te_set), .o_rdata (rdata),
        .o_cr_chsel (cr_chsel), .o_cr_pl (cr_pl), .o_cr_msize (cr_msize),
        .o_cr_psize (cr_psize), .o_cr_minc (cr_minc), .o_cr_pinc (cr_pinc),
        .o_cr_dir (cr_dir), .o_cr_tcie (cr_tcie), .o_cr_htie (cr_htie),
        .o_cr_teie (cr_teie), .o_cr_en (cr_en), .o_ndtr (ndtr),
        .o_par (par), .o_mar (mar), .o_dir_mem_to_periph (dir_m2p),
        .o_isr_tcif (isr_tcif), .o_isr_htif (isr_htif), .o_isr_teif (isr_teif)
    );

    // byte address of register off in stream s
    function automatic logic [31:0] reg_addr(input int s, input int off);
        return 32'((2 + 4*s + off) * 4);
    endfunction

    // CR word rebuilt from the field outputs of stream s
    function automatic logic [31:0] cr_ports(input int s);
        return {4'h0, cr_chsel[s], 7'h0, cr_pl[s], 1'b0, cr_msize[s], cr_psize[s],
                cr_minc[s], cr_pinc[s], 1'b0, cr_dir[s], 1'b0, cr_tcie[s], cr_htie[s],
                cr_teie[s], 1'b0, cr_en[s]};
    endfunction

    function automatic logic [31:0] merge_lanes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  lanes
    );
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s (%s): expected %h, actual %h", test_name, what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic write_reg(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
        @(posedge clk);
        #drive_delay;
        addr     = a;
        wdata    = d;
        strobe   = be;
        write_en = 1'b1;
        @(posedge clk);    // lands here
        #drive_delay;
        write_en = 1'b0;
    endtask

    task automatic check_reg(input string what, input logic [31:0] a,
                             input logic [31:0] expected);
        logic [31:0] got;
        @(posedge clk);
        #drive_delay;
        addr    = a;
        read_en = 1'b1;
        @(negedge clk);
        got = rdata;
        @(posedge clk);
        #drive_delay;
        read_en = 1'b0;
        check_value(what, expected, got);
    endtask

    task automatic decrement(input int s);
        @(posedge clk);
        #drive_delay;
        ndtr_decr[s] = 1'b1;
        @(posedge clk);
        #drive_delay;
        ndtr_decr[s] = 1'b0;
    endtask

    task automatic pulse_error(input int s);
        @(posedge clk);
        #drive_delay;
        te_set[s] = 1'b1;
        @(posedge clk);
        #drive_delay;
        te_set[s] = 1'b0;
    endtask

    task automatic wait_enable(input int s, input logic level);
        int cycles;
        cycles = 0;
        while (cr_en[s] !== level && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (cr_en[s] === level) else begin
            $display("%s: stream %0d enable did not go to %0b within %0d cycles",
                     test_name, s, level, wait_limit);
            test_errs++;
        end
    endtask

    task automatic wait_error_flag(input int s);
        int cycles;
        cycles = 0;
        while (isr_teif[s] !== 1'b1 && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (isr_teif[s] === 1'b1) else begin
            $display("%s: stream %0d error flag never set", test_name, s);
            test_errs++;
        end
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            pass_count++;
            $display("[pass] %s", test_name);
        end else begin
            fail_count++;
            $display("[fail] %s with %0d wrong check(s)", test_name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        int unsigned seed;
        int          cycles;
        int          n;
        int          first_half;
        logic [31:0] d;
        logic [3:0]  be;
        addr       = '0;
        write_en   = 1'b0;
        read_en    = 1'b0;
        strobe     = '0;
        wdata      = '0;
        exp_cr     = '0;
        test_errs  = 0;
        pass_count = 0;
        fail_count = 0;
        for (int s = 0; s < n_streams; s++) begin
            ndtr_decr[s] = 1'b0;
            te_set[s]    = 1'b0;
            exp_par[s]   = '0;
            exp_mar[s]   = '0;
        end
        seed = $urandom(32'hbd56);
        cycles = 0;
        while (nreset !== 1'b1 && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        assert (nreset === 1'b1) else begin
            $display("reset was never released");
            fail_count++;
        end

        test_name = "reset_values";
        check_reg("lisr", lisr_addr, 32'h0);
        check_reg("lifcr", lifcr_addr, 32'h0);
        for (int s = 0; s < n_streams; s++) begin
            for (int r = 0; r < 4; r++) check_reg("stream reg", reg_addr(s, r), 32'h0);
            check_value("en and flags", 32'h0,
                        {28'h0, cr_en[s], isr_tcif[s], isr_htif[s], isr_teif[s]});
        end
        end_test();

        test_name = "par_mar_strobes";
        for (int s = 0; s < n_streams; s++) begin
            for (int i = 0; i < 4; i++) begin
                d  = $urandom;
                be = 4'($urandom);
                write_reg(reg_addr(s, 2), d, be);
                exp_par[s] = merge_lanes(exp_par[s], d, be);
                check_reg("par read", reg_addr(s, 2), exp_par[s]);
                check_value("par port", exp_par[s], par[s]);
                d  = $urandom;
                be = 4'($urandom);
                write_reg(reg_addr(s, 3), d, be);
                exp_mar[s] = merge_lanes(exp_mar[s], d, be);
                check_reg("mar read", reg_addr(s, 3), exp_mar[s]);
                check_value("mar port", exp_mar[s], mar[s]);
            end
        end
        end_test();

        test_name = "cr_protect";
        d  = ($urandom & ~32'hc1) | 32'h40;    // idle write, memory to peripheral
        be = 4'($urandom) | 4'h1;
        write_reg(reg_addr(0, 0), d, be);
        exp_cr = merge_lanes(exp_cr, d & cr_fields, be);
        check_reg("cr idle", reg_addr(0, 0), exp_cr);
        check_value("cr ports", exp_cr, cr_ports(0));
        check_value("m2p port", 32'h1, 32'(dir_m2p[0]));
        write_reg(reg_addr(0, 1), 32'd10, 4'hf);
        write_reg(reg_addr(0, 0), exp_cr | 32'h1, 4'b0001);
        exp_cr[0] = 1'b1;
        wait_enable(0, 1'b1);
        d = $urandom | 32'h1;
        write_reg(reg_addr(0, 0), d, 4'hf);
        exp_cr[4:2] = d[4:2];      // only the interrupt enables move
        check_reg("cr running", reg_addr(0, 0), exp_cr);
        check_value("cr ports running", exp_cr, cr_ports(0));
        write_reg(reg_addr(0, 1), $urandom, 4'hf);
        write_reg(reg_addr(0, 2), $urandom, 4'hf);
        write_reg(reg_addr(0, 3), $urandom, 4'hf);
        check_reg("ndtr locked", reg_addr(0, 1), 32'd10);
        check_reg("par locked", reg_addr(0, 2), exp_par[0]);
        check_reg("mar locked", reg_addr(0, 3), exp_mar[0]);
        write_reg(reg_addr(0, 0), exp_cr & ~32'h1, 4'b0001);
        exp_cr[0] = 1'b0;
        wait_enable(0, 1'b0);
        check_reg("cr stopped", reg_addr(0, 0), exp_cr);
        end_test();

        test_name = "enable_count";
        n = 4 + ($urandom % 16);
        write_reg(reg_addr(1, 1), 32'(n), 4'hf);
        write_reg(reg_addr(1, 0), 32'h1, 4'b0001);
        wait_enable(1, 1'b1);
        check_value("ndtr loaded", 32'(n), 32'(ndtr[1]));
        first_half = n - n/2 + 1; // one past the half point
        repeat (first_half) decrement(1);
        check_value("tc and ht midway", 32'h1, {30'h0, isr_tcif[1], isr_htif[1]});
        repeat (n - first_half) decrement(1);
        wait_enable(1, 1'b0);
        check_reg("ndtr at end", reg_addr(1, 1), 32'h0);
        check_value("tc and ht at end", 32'h3, {30'h0, isr_tcif[1], isr_htif[1]});
        check_reg("lisr", lisr_addr, 32'h0000_3000);
        end_test();

        test_name = "error_flag_clear";
        pulse_error(0);
        pulse_error(1);
        wait_error_flag(1);
        check_reg("lisr set", lisr_addr, 32'h0000_3808);
        check_reg("lifcr reads zero", lifcr_addr, 32'h0);
        write_reg(lifcr_addr, 32'h0000_0800, 4'b0010);    // stream 1 te only
        check_reg("lisr cleared", lisr_addr, 32'h0000_3008);
        check_value("stream 1 flags", 32'h6, {29'h0, isr_tcif[1], isr_htif[1], isr_teif[1]});
        check_value("stream 0 te", 32'h1, {31'h0, isr_teif[0]});
        end_test();

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: all.f
source/dma_pkg.sv
source/dma_reg_decode.sv
source/dma_stream_ctrl.sv
source/dma_stream_flags.sv
source/dma_read_mux.sv
source/dma_regs_top.sv
bench/tb_clock_gen.sv
bench/tb_dma_regs.sv
